// ==== mshr_macros.svh ====
`ifndef MSHR_MACROS_SVH
`define MSHR_MACROS_SVH

// ------------------------------------------------------------
// mshr sizing
// ------------------------------------------------------------

// number of outstanding misses tracked
`define MSHR_ENTRY_NUM 8

// must cover MSHR_ENTRY_NUM
`define MSHR_IDX_WIDTH 3

// miss line address
`define MSHR_ADDR_WIDTH 32

`endif

// ==== mshr_pkg.sv ====
`default_nettype none

`include "mshr_macros.svh"

package mshr_pkg;

    // names one mshr entry
    typedef logic [`MSHR_IDX_WIDTH-1:0] entry_idx_t;

    // line address of a miss
    typedef logic [`MSHR_ADDR_WIDTH-1:0] addr_t;

    // life cycle of one entry
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // free for allocation
        ISSUE     = 2'd1,  // waiting for downstream grant
        WAIT_FILL = 2'd2   // read sent, waiting for linefill
    } entry_state_e;

endpackage

`default_nettype wire

// ==== mshr_alloc.sv ====
`default_nettype none

`include "mshr_macros.svh"

module mshr_alloc (
    input  wire logic                           req_vld,
    input  wire logic [`MSHR_ENTRY_NUM-1:0]     entry_busy,
    output mshr_pkg::entry_idx_t                alloc_idx,
    output logic      [`MSHR_ENTRY_NUM-1:0]     alloc_we,
    output logic                                mshr_stall
);

    logic accept;

    assign mshr_stall = &entry_busy;          // no idle entry left
    assign accept     = req_vld && !mshr_stall;

    // lowest idle entry wins
    // walk downwards so the last hit is the smallest index
    always_comb begin
        alloc_idx = '0;
        for (int i = `MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (!entry_busy[i]) begin
                alloc_idx = mshr_pkg::entry_idx_t'(i);
            end
        end
    end

    // one-hot write strobe, only on a taken request
    always_comb begin
        alloc_we = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (accept && (alloc_idx == mshr_pkg::entry_idx_t'(i))) begin
                alloc_we[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mshr_entry.sv ====
`default_nettype none

module mshr_entry (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   alloc_we,
    input  wire mshr_pkg::addr_t        req_addr,
    input  wire logic                   grant,
    input  wire logic                   fill,
    output logic                        busy,
    output logic                        issue_req,
    output logic                        wait_fill,
    output mshr_pkg::addr_t             entry_addr
);

    mshr_pkg::entry_state_e state;
    mshr_pkg::entry_state_e state_nxt;

    // ------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            mshr_pkg::IDLE: begin
                if (alloc_we) begin
                    state_nxt = mshr_pkg::ISSUE;
                end
            end
            mshr_pkg::ISSUE: begin
                if (grant) begin          // txreq accepted downstream
                    state_nxt = mshr_pkg::WAIT_FILL;
                end
            end
            mshr_pkg::WAIT_FILL: begin
                if (fill) begin
                    state_nxt = mshr_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = mshr_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mshr_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------
    // miss address
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            entry_addr <= req_addr;
        end
    end

    // status to allocator, arbiter and fill decode
    assign busy      = (state != mshr_pkg::IDLE);
    assign issue_req = (state == mshr_pkg::ISSUE);
    assign wait_fill = (state == mshr_pkg::WAIT_FILL);

endmodule

`default_nettype wire

// ==== mshr_txreq_arb.sv ====
`default_nettype none

`include "mshr_macros.svh"

module mshr_txreq_arb (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`MSHR_ENTRY_NUM-1:0] issue_req,
    input  wire mshr_pkg::addr_t            entry_addr [`MSHR_ENTRY_NUM-1:0],
    input  wire logic                       txreq_rdy,
    output logic      [`MSHR_ENTRY_NUM-1:0] grant,
    output logic                            txreq_vld,
    output mshr_pkg::addr_t                 txreq_addr,
    output mshr_pkg::entry_idx_t            txreq_idx
);

    mshr_pkg::entry_idx_t ptr;        // last granted index
    mshr_pkg::entry_idx_t rr_idx;
    mshr_pkg::entry_idx_t lock_idx;
    logic                 lock_vld;

    // round robin, starts one past ptr
    always_comb begin
        int j;
        rr_idx = ptr;
        for (int k = `MSHR_ENTRY_NUM; k >= 1; k--) begin
            j = (int'(ptr) + k) % `MSHR_ENTRY_NUM;
            if (issue_req[j]) begin
                rr_idx = mshr_pkg::entry_idx_t'(j);
            end
        end
    end

    assign txreq_vld  = |issue_req;
    assign txreq_idx  = lock_vld ? lock_idx : rr_idx;  // keep offer stable under back-pressure
    assign txreq_addr = entry_addr[txreq_idx];

    always_comb begin
        grant = '0;
        if (txreq_vld && txreq_rdy) begin
            grant[txreq_idx] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // pointer and lock
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            lock_vld <= 1'b0;
            lock_idx <= '0;
        end else if (txreq_vld && txreq_rdy) begin
            ptr      <= txreq_idx;
            lock_vld <= 1'b0;
        end else if (txreq_vld) begin
            lock_vld <= 1'b1;
            lock_idx <= txreq_idx;
        end
    end

endmodule

`default_nettype wire

// ==== mshr_top.sv ====
`default_nettype none

`include "mshr_macros.svh"

module mshr_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // miss request
    input  wire logic                   req_vld,
    input  wire mshr_pkg::addr_t        req_addr,
    output mshr_pkg::entry_idx_t        alloc_idx,
    output logic                        mshr_stall,
    // downstream read request
    output logic                        txreq_vld,
    output mshr_pkg::addr_t             txreq_addr,
    output mshr_pkg::entry_idx_t        txreq_idx,
    input  wire logic                   txreq_rdy,
    // linefill completion
    input  wire logic                   fill_done,
    input  wire mshr_pkg::entry_idx_t   fill_done_idx,
    // entry release
    output logic                        release_vld,
    output mshr_pkg::entry_idx_t        release_idx
);

    logic [`MSHR_ENTRY_NUM-1:0] entry_busy;
    logic [`MSHR_ENTRY_NUM-1:0] alloc_we;
    logic [`MSHR_ENTRY_NUM-1:0] issue_req;
    logic [`MSHR_ENTRY_NUM-1:0] wait_fill;
    logic [`MSHR_ENTRY_NUM-1:0] grant;
    logic [`MSHR_ENTRY_NUM-1:0] fill_vec;
    mshr_pkg::addr_t            entry_addr [`MSHR_ENTRY_NUM-1:0];

    mshr_alloc u_alloc (
        .req_vld    (req_vld),
        .entry_busy (entry_busy),
        .alloc_idx  (alloc_idx),
        .alloc_we   (alloc_we),
        .mshr_stall (mshr_stall)
    );

    // ------------------------------------------------------------
    // entry array
    // ------------------------------------------------------------

    for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : gen_entry
        mshr_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .alloc_we   (alloc_we[i]),
            .req_addr   (req_addr),
            .grant      (grant[i]),
            .fill       (fill_vec[i]),
            .busy       (entry_busy[i]),
            .issue_req  (issue_req[i]),
            .wait_fill  (wait_fill[i]),
            .entry_addr (entry_addr[i])
        );
    end

    mshr_txreq_arb u_txreq_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_req  (issue_req),
        .entry_addr (entry_addr),
        .txreq_rdy  (txreq_rdy),
        .grant      (grant),
        .txreq_vld  (txreq_vld),
        .txreq_addr (txreq_addr),
        .txreq_idx  (txreq_idx)
    );

    // fill decode, stray fills are dropped here
    always_comb begin
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            fill_vec[i] = fill_done && wait_fill[i] &&
                          (fill_done_idx == mshr_pkg::entry_idx_t'(i));
        end
    end

    // release pulse, one cycle after the honoured fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            release_vld <= 1'b0;
        end else begin
            release_vld <= |fill_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (|fill_vec) begin
            release_idx <= fill_done_idx;
        end
    end

endmodule

`default_nettype wire

// ==== tb_mshr.sv ====
`default_nettype none

`include "mshr_macros.svh"

module tb_mshr;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string                name;
        logic                 req_vld;
        logic                 txreq_rdy;
        logic                 fill_done;
        mshr_pkg::entry_idx_t fill_idx;
        int                   hold;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_vld;
    mshr_pkg::addr_t      req_addr;
    mshr_pkg::entry_idx_t alloc_idx;
    logic                 mshr_stall;
    logic                 txreq_vld;
    mshr_pkg::addr_t      txreq_addr;
    mshr_pkg::entry_idx_t txreq_idx;
    logic                 txreq_rdy;
    logic                 fill_done;
    mshr_pkg::entry_idx_t fill_done_idx;
    logic                 release_vld;
    mshr_pkg::entry_idx_t release_idx;

    step_t       steps [$];
    bit          table_ready;
    int          errors;
    logic [31:0] lcg_state;

    // ------------------------------------------------------------
    // reference model state and predictions
    // ------------------------------------------------------------
    mshr_pkg::entry_state_e m_state [`MSHR_ENTRY_NUM];
    mshr_pkg::addr_t        m_addr  [`MSHR_ENTRY_NUM];
    mshr_pkg::entry_idx_t   m_ptr;
    mshr_pkg::entry_idx_t   m_lock_idx;
    mshr_pkg::entry_idx_t   m_rel_idx;
    logic                   m_lock_vld;
    logic                   m_rel_vld;
    logic                   p_stall;
    logic                   p_txvld;
    mshr_pkg::entry_idx_t   p_alloc;
    mshr_pkg::entry_idx_t   p_txidx;

    mshr_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_vld       (req_vld),
        .req_addr      (req_addr),
        .alloc_idx     (alloc_idx),
        .mshr_stall    (mshr_stall),
        .txreq_vld     (txreq_vld),
        .txreq_addr    (txreq_addr),
        .txreq_idx     (txreq_idx),
        .txreq_rdy     (txreq_rdy),
        .fill_done     (fill_done),
        .fill_done_idx (fill_done_idx),
        .release_vld   (release_vld),
        .release_idx   (release_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input mshr_pkg::entry_idx_t exp,
                             input mshr_pkg::entry_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input mshr_pkg::addr_t exp,
                              input mshr_pkg::addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic add_step(input string name, input logic rv, input logic rdy,
                            input logic fd, input int fidx, input int hold);
        step_t s;
        s.name      = name;
        s.req_vld   = rv;
        s.txreq_rdy = rdy;
        s.fill_done = fd;
        s.fill_idx  = mshr_pkg::entry_idx_t'(fidx);
        s.hold      = hold;
        steps.push_back(s);
    endtask

    // outputs expected from the model state and current inputs
    task automatic predict();
        int  j;
        logic found;
        p_stall = 1'b1;
        p_alloc = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (p_stall && m_state[i] == mshr_pkg::IDLE) begin
                p_stall = 1'b0;
                p_alloc = mshr_pkg::entry_idx_t'(i);
            end
        end
        found   = 1'b0;
        p_txidx = '0;
        for (int k = 1; k <= `MSHR_ENTRY_NUM; k++) begin
            j = (int'(m_ptr) + k) % `MSHR_ENTRY_NUM;
            if (!found && m_state[j] == mshr_pkg::ISSUE) begin
                found   = 1'b1;
                p_txidx = mshr_pkg::entry_idx_t'(j);
            end
        end
        p_txvld = found;
        if (m_lock_vld) begin
            p_txidx = m_lock_idx;   // offer held under back-pressure
        end
    endtask

    task automatic check_outputs(input string name);
        check_bit({name, " mshr_stall"}, p_stall, mshr_stall);
        if (!p_stall) begin
            check_idx({name, " alloc_idx"}, p_alloc, alloc_idx);
        end
        check_bit({name, " txreq_vld"}, p_txvld, txreq_vld);
        if (p_txvld) begin
            check_idx({name, " txreq_idx"}, p_txidx, txreq_idx);
            check_addr({name, " txreq_addr"}, m_addr[p_txidx], txreq_addr);
        end
        check_bit({name, " release_vld"}, m_rel_vld, release_vld);
        if (m_rel_vld) begin
            check_idx({name, " release_idx"}, m_rel_idx, release_idx);
        end
    endtask

    // advance the model across the coming edge
    task automatic update_model();
        logic accept;
        logic xfer;
        logic fill_ok;
        accept  = req_vld && !p_stall;
        xfer    = p_txvld && txreq_rdy;
        fill_ok = fill_done && (m_state[fill_done_idx] == mshr_pkg::WAIT_FILL);
        if (accept) begin
            m_state[p_alloc] = mshr_pkg::ISSUE;
            m_addr[p_alloc]  = req_addr;
        end
        if (xfer) begin
            m_state[p_txidx] = mshr_pkg::WAIT_FILL;
            m_ptr            = p_txidx;
            m_lock_vld       = 1'b0;
        end else if (p_txvld) begin
            m_lock_vld = 1'b1;
            m_lock_idx = p_txidx;
        end
        if (fill_ok) begin
            m_state[fill_done_idx] = mshr_pkg::IDLE;
            m_rel_idx              = fill_done_idx;
        end
        m_rel_vld = fill_ok;
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        add_step("after_reset",      0, 0, 0, 0, 2);
        add_step("fill_all",         1, 0, 0, 0, 8);
        add_step("stalled_req",      1, 0, 0, 0, 3);  // ninth request must not land
        add_step("drain_rr",         0, 1, 0, 0, 8);
        add_step("fill_5",           0, 0, 1, 5, 1);
        add_step("stray_fill_5",     0, 0, 1, 5, 1);  // already idle
        add_step("fill_2",           0, 0, 1, 2, 1);
        add_step("release_gap",      0, 0, 0, 0, 2);
        add_step("reuse_low",        1, 0, 0, 0, 1);
        add_step("stray_fill_issue", 0, 0, 1, 2, 1);  // entry still in ISSUE
        add_step("reuse_next",       1, 0, 0, 0, 1);
        add_step("refill_stall",     1, 0, 0, 0, 2);
        add_step("backpressure",     0, 0, 0, 0, 3);
        add_step("drain_wrap",       0, 1, 0, 0, 3);
        add_step("fill_tail",        0, 0, 1, 7, 1);
        add_step("fill_head",        0, 1, 1, 0, 1);
        add_step("mixed",            1, 1, 0, 0, 4);
        // lock a middle entry, then queue one below and one above it
        add_step("fill_mid",         0, 0, 1, 4, 1);
        add_step("lock_mid",         1, 0, 0, 0, 1);
        add_step("fill_low",         0, 0, 1, 1, 1);
        add_step("fill_high",        0, 0, 1, 6, 1);
        add_step("refill_both",      1, 0, 0, 0, 2);
        add_step("drain_order",      0, 1, 0, 0, 4);  // 4, then 6 before 1
        add_step("settle",           0, 0, 0, 0, 2);
    endtask

    initial begin
        rst_n         = 1'b0;
        req_vld       = 1'b0;
        req_addr      = '0;
        txreq_rdy     = 1'b0;
        fill_done     = 1'b0;
        fill_done_idx = '0;
        errors        = 0;
        lcg_state     = 32'hc98d;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            m_state[i] = mshr_pkg::IDLE;
            m_addr[i]  = '0;
        end
        m_ptr      = '0;
        m_lock_vld = 1'b0;
        m_lock_idx = '0;
        m_rel_vld  = 1'b0;
        m_rel_idx  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (steps[s]) begin
            for (int c = 0; c < steps[s].hold; c++) begin
                @(posedge clk);
                #1;
                req_vld = steps[s].req_vld;
                if (steps[s].req_vld) begin
                    lcg_state = lcg_next(lcg_state);
                    req_addr  = lcg_state;
                end
                txreq_rdy     = steps[s].txreq_rdy;
                fill_done     = steps[s].fill_done;
                fill_done_idx = steps[s].fill_idx;
                #2;         // outputs settled, edge still 1 ns away
                predict();
                check_outputs(steps[s].name);
                update_model();
            end
        end
        @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        int max_hold;
        wait (table_ready);
        max_hold = 1;
        foreach (steps[i]) begin
            if (steps[i].hold > max_hold) begin
                max_hold = steps[i].hold;
            end
        end
        #((steps.size() * max_hold + 4) * 4 + 200);
        $display("timeout: stimulus table did not complete in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mshr.f ====
+incdir+.
mshr_pkg.sv
mshr_alloc.sv
mshr_entry.sv
mshr_txreq_arb.sv
mshr_top.sv
tb_mshr.sv
